// File: Makefile
TOP := tb_icache_subsys

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f icache_subsys.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: icache_cfg_regs.sv
`timescale 1ns/1ps

module icache_cfg_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cfg_wr,
    input  icache_pkg::cfg_reg_e               cfg_addr,
    input  logic [31:0]                        cfg_wdata,
    output logic [31:0]                        cfg_rdata,
    input  logic                               hit_pulse,
    input  logic                               miss_pulse,
    output logic                               cache_on,
    output logic                               fence_active,
    output logic [icache_pkg::LINE_ADDR_W-1:0] fence_index
);

    logic [icache_pkg::CNT_W-1:0] hit_count;
    logic [icache_pkg::CNT_W-1:0] miss_count;

    ////////////////////
    // Enable and fence
    always_ff @(posedge clk) begin
        if (rst) begin
            cache_on     <= 1'b0;
            fence_active <= 1'b0;
            fence_index  <= '0;
        end else begin
            if (cfg_wr && cfg_addr == icache_pkg::REG_CTRL) begin
                cache_on <= cfg_wdata[0];
            end
            // One pass over every set, ends when the index wraps
            if (cfg_wr && cfg_addr == icache_pkg::REG_FENCE) begin
                fence_active <= 1'b1;
            end else if (fence_active && &fence_index) begin
                fence_active <= 1'b0;
            end
            if (fence_active) begin
                fence_index <= fence_index + 1'b1;
            end
        end
    end

    ////////////////////
    // Hit and miss counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (cfg_wr && cfg_addr == icache_pkg::REG_HITS) begin
                hit_count <= '0;
            end else if (hit_pulse) begin
                hit_count <= hit_count + 1'b1;
            end
            if (cfg_wr && cfg_addr == icache_pkg::REG_MISSES) begin
                miss_count <= '0;
            end else if (miss_pulse) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        case (cfg_addr)
            icache_pkg::REG_CTRL:   cfg_rdata = {31'd0, cache_on};
            icache_pkg::REG_STATUS: cfg_rdata = {31'd0, fence_active};
            icache_pkg::REG_HITS:   cfg_rdata = hit_count;
            icache_pkg::REG_MISSES: cfg_rdata = miss_count;
            default:                cfg_rdata = '0;
        endcase
    end

endmodule

// File: icache_core.sv
`timescale 1ns/1ps

module icache_core (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               fetch_req,
    input  logic [icache_pkg::ADDR_W-1:0]      fetch_addr,
    output logic                               fetch_ready,
    output logic                               fetch_valid,
    output logic [31:0]                        fetch_data,
    input  logic                               cache_on,
    input  logic                               fence_active,
    input  logic [icache_pkg::LINE_ADDR_W-1:0] fence_index,
    output logic                               mem_request,
    output logic [29:0]                        mem_addr,
    output logic [4:0]                         mem_rlen,
    input  logic                               mem_ack,
    input  logic                               mem_rvalid,
    input  logic [31:0]                        mem_rdata,
    output logic                               hit_pulse,
    output logic                               miss_pulse
);

    localparam int LINE_LO = icache_pkg::SUB_LINE_W + 2;
    localparam int TAG_LO  = LINE_LO + icache_pkg::LINE_ADDR_W;

    icache_pkg::fill_state_e fill_state;

    logic                                fifo_push;
    logic                                fifo_pop;
    logic [icache_pkg::ADDR_W-1:0]       fifo_data;
    logic                                fifo_valid;
    logic                                fifo_full;

    logic                                accepted;
    logic                                new_request;
    logic [icache_pkg::ADDR_W-1:0]       new_request_addr;
    logic                                request_in_progress;
    logic                                second_cycle;
    logic [icache_pkg::ADDR_W-1:0]       second_cycle_addr;
    logic                                second_cycle_on;

    logic                                tag_hit;
    logic [icache_pkg::WAYS-1:0]         hit_way;
    logic [icache_pkg::WAYS-1:0]         repl_way;
    logic [icache_pkg::WAYS-1:0][31:0]   way_data;
    logic [31:0]                         hit_word;

    logic [icache_pkg::SUB_LINE_W-1:0]   word_count;
    logic                                fill_word;
    logic                                line_complete;
    logic                                miss_data_valid;

    ////////////////////
    // Request sequencing
    assign fetch_ready = ~fifo_full & ~fence_active;
    assign accepted    = fetch_req & fetch_ready;

    // Queued addresses go first so order holds
    assign new_request = (accepted | fifo_valid) & (~request_in_progress | tag_hit)
                       & (fill_state == icache_pkg::FILL_IDLE);
    assign new_request_addr = fifo_valid ? fifo_data : fetch_addr;

    assign fifo_push = accepted & (~new_request | fifo_valid);
    assign fifo_pop  = new_request & fifo_valid;

    icache_input_fifo input_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (fifo_push),
        .pop      (fifo_pop),
        .data_in  (fetch_addr),
        .data_out (fifo_data),
        .valid    (fifo_valid),
        .full     (fifo_full)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            request_in_progress <= 1'b0;
            second_cycle        <= 1'b0;
        end else begin
            request_in_progress <= (request_in_progress & ~fetch_valid) | new_request;
            second_cycle        <= new_request;
        end
    end

    always_ff @(posedge clk) begin
        if (new_request) begin
            second_cycle_addr <= new_request_addr;
            second_cycle_on   <= cache_on;
        end
    end

    assign hit_pulse  = tag_hit;
    assign miss_pulse = second_cycle & second_cycle_on & ~tag_hit;

    ////////////////////
    // Line fill FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_state <= icache_pkg::FILL_IDLE;
        end else begin
            case (fill_state)
                icache_pkg::FILL_IDLE: begin
                    // Disabled cache never hits, so every request lands here
                    if (second_cycle && !tag_hit) begin
                        fill_state <= icache_pkg::FILL_REQ;
                    end
                end
                icache_pkg::FILL_REQ: begin
                    if (mem_ack) begin
                        fill_state <= icache_pkg::FILL_DATA;
                    end
                end
                icache_pkg::FILL_DATA: begin
                    if (line_complete) begin
                        fill_state <= icache_pkg::FILL_IDLE;
                    end
                end
                default: fill_state <= icache_pkg::FILL_IDLE;
            endcase
        end
    end

    assign mem_request = (fill_state == icache_pkg::FILL_REQ);
    assign mem_addr    = {second_cycle_addr[icache_pkg::ADDR_W-1:LINE_LO],
                          icache_pkg::SUB_LINE_W'(0)};
    assign mem_rlen    = icache_pkg::MEM_RLEN;

    assign fill_word     = (fill_state == icache_pkg::FILL_DATA) & mem_rvalid;
    assign line_complete = fill_word & (&word_count);

    always_ff @(posedge clk) begin
        if (rst) begin
            word_count <= '0;
        end else if (fill_word) begin
            word_count <= word_count + 1'b1;
        end
    end

    assign miss_data_valid = fill_word & (word_count == second_cycle_addr[2 +: icache_pkg::SUB_LINE_W]);

    // Round-robin victim, rotates once per completed fill
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= icache_pkg::WAYS'(1);
        end else if (line_complete) begin
            repl_way <= {repl_way[icache_pkg::WAYS-2:0], repl_way[icache_pkg::WAYS-1]};
        end
    end

    ////////////////////
    // Tag and data storage
    icache_tag_banks tag_banks (
        .clk          (clk),
        .rst          (rst),
        .lookup_en    (new_request & cache_on),
        .lookup_index (new_request_addr[LINE_LO +: icache_pkg::LINE_ADDR_W]),
        .cmp_tag      (second_cycle_addr[icache_pkg::ADDR_W-1:TAG_LO]),
        .update       (mem_request & mem_ack),
        .update_way   (repl_way),
        .update_index (second_cycle_addr[LINE_LO +: icache_pkg::LINE_ADDR_W]),
        .fence_active (fence_active),
        .fence_index  (fence_index),
        .tag_hit      (tag_hit),
        .hit_way      (hit_way)
    );

    icache_data_bank data_bank (
        .clk     (clk),
        .wr_en   (fill_word),
        .wr_way  (repl_way),
        .wr_addr ({second_cycle_addr[LINE_LO +: icache_pkg::LINE_ADDR_W], word_count}),
        .wr_data (mem_rdata),
        .rd_en   (new_request),
        .rd_addr (new_request_addr[TAG_LO-1:2]),
        .rd_data (way_data)
    );

    ////////////////////
    // Output select
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (hit_way[w]) begin
                hit_word = hit_word | way_data[w];
            end
        end
    end

    // Memory bypass wins on a miss
    assign fetch_data  = miss_data_valid ? mem_rdata : hit_word;
    assign fetch_valid = miss_data_valid | tag_hit;

endmodule

// File: icache_data_bank.sv
`timescale 1ns/1ps

module icache_data_bank (
    input  logic                                                  clk,
    input  logic                                                  wr_en,
    input  logic [icache_pkg::WAYS-1:0]                           wr_way,
    input  logic [icache_pkg::LINE_ADDR_W+icache_pkg::SUB_LINE_W-1:0] wr_addr,
    input  logic [31:0]                                           wr_data,
    input  logic                                                  rd_en,
    input  logic [icache_pkg::LINE_ADDR_W+icache_pkg::SUB_LINE_W-1:0] rd_addr,
    output logic [icache_pkg::WAYS-1:0][31:0]                     rd_data
);

    localparam int DEPTH = icache_pkg::LINES * icache_pkg::LINE_WORDS;

    logic [31:0] mem [icache_pkg::WAYS][DEPTH];

    // One write column per way, registered read on all ways
    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (wr_en && wr_way[w]) begin
                mem[w][wr_addr] <= wr_data;
            end
            if (rd_en) begin
                rd_data[w] <= mem[w][rd_addr];
            end
        end
    end

endmodule

// File: icache_input_fifo.sv
`timescale 1ns/1ps

module icache_input_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  logic                          pop,
    input  logic [icache_pkg::ADDR_W-1:0] data_in,
    output logic [icache_pkg::ADDR_W-1:0] data_out,
    output logic                          valid,
    output logic                          full
);

    logic [icache_pkg::ADDR_W-1:0] entries [2];
    logic                          wr_ptr;
    logic                          rd_ptr;
    logic [1:0]                    count;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Simultaneous push and pop keeps the count
            count <= count + 2'(push) - 2'(pop);
        end
    end

    assign data_out = entries[rd_ptr];
    assign valid    = (count != 2'd0);
    assign full     = (count == 2'd2);

endmodule

// File: icache_pkg.sv
package icache_pkg;

    ////////////////////
    // Cache geometry
    localparam int ADDR_W      = 32;
    localparam int WAYS        = 2;
    localparam int LINE_WORDS  = 8;
    localparam int SUB_LINE_W  = 3;
    localparam int LINES       = 64;
    localparam int LINE_ADDR_W = 6;
    // 32 minus byte, word and set bits
    localparam int TAG_W       = 21;

    // Burst length minus one
    localparam logic [4:0] MEM_RLEN = 5'(LINE_WORDS - 1);

    localparam int CNT_W = 32;

    ////////////////////
    // Register map
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_FENCE  = 3'd1,
        REG_STATUS = 3'd2,
        REG_HITS   = 3'd3,
        REG_MISSES = 3'd4
    } cfg_reg_e;

    // Line fill sequencing
    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,
        FILL_REQ  = 2'd1,
        FILL_DATA = 2'd2
    } fill_state_e;

endpackage

// File: icache_subsys.f
icache_pkg.sv
icache_input_fifo.sv
icache_tag_banks.sv
icache_data_bank.sv
icache_core.sv
icache_cfg_regs.sv
icache_subsys.sv
tb_clock_gen.sv
tb_icache_subsys.sv

// File: icache_subsys.sv
`timescale 1ns/1ps

module icache_subsys (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_req,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    output logic                          fetch_ready,
    output logic                          fetch_valid,
    output logic [31:0]                   fetch_data,
    output logic                          mem_request,
    output logic [29:0]                   mem_addr,
    output logic [4:0]                    mem_rlen,
    input  logic                          mem_ack,
    input  logic                          mem_rvalid,
    input  logic [31:0]                   mem_rdata,
    input  logic                          cfg_wr,
    input  icache_pkg::cfg_reg_e          cfg_addr,
    input  logic [31:0]                   cfg_wdata,
    output logic [31:0]                   cfg_rdata
);

    logic                               cache_on;
    logic                               fence_active;
    logic [icache_pkg::LINE_ADDR_W-1:0] fence_index;
    logic                               hit_pulse;
    logic                               miss_pulse;

    icache_cfg_regs cfg_regs (
        .clk          (clk),
        .rst          (rst),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata),
        .hit_pulse    (hit_pulse),
        .miss_pulse   (miss_pulse),
        .cache_on     (cache_on),
        .fence_active (fence_active),
        .fence_index  (fence_index)
    );

    icache_core core (
        .clk          (clk),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_ready  (fetch_ready),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .cache_on     (cache_on),
        .fence_active (fence_active),
        .fence_index  (fence_index),
        .mem_request  (mem_request),
        .mem_addr     (mem_addr),
        .mem_rlen     (mem_rlen),
        .mem_ack      (mem_ack),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .hit_pulse    (hit_pulse),
        .miss_pulse   (miss_pulse)
    );

endmodule

// File: icache_tag_banks.sv
`timescale 1ns/1ps

module icache_tag_banks (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               lookup_en,
    input  logic [icache_pkg::LINE_ADDR_W-1:0] lookup_index,
    input  logic [icache_pkg::TAG_W-1:0]       cmp_tag,
    input  logic                               update,
    input  logic [icache_pkg::WAYS-1:0]        update_way,
    input  logic [icache_pkg::LINE_ADDR_W-1:0] update_index,
    input  logic                               fence_active,
    input  logic [icache_pkg::LINE_ADDR_W-1:0] fence_index,
    output logic                               tag_hit,
    output logic [icache_pkg::WAYS-1:0]        hit_way
);

    logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::WAYS][icache_pkg::LINES];
    logic [icache_pkg::LINES-1:0] valid_bits [icache_pkg::WAYS];
    logic [icache_pkg::TAG_W-1:0] tag_r [icache_pkg::WAYS];
    logic [icache_pkg::WAYS-1:0]  valid_r;
    logic                         lookup_r;

    ////////////////////
    // Tag RAM
    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            // Fill writes the tag of the line being fetched
            if (update && update_way[w]) begin
                tag_mem[w][update_index] <= cmp_tag;
            end
            if (lookup_en) begin
                tag_r[w]   <= tag_mem[w][lookup_index];
                valid_r[w] <= valid_bits[w][lookup_index];
            end
        end
    end

    ////////////////////
    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                valid_bits[w] <= '0;
            end
            lookup_r <= 1'b0;
        end else begin
            lookup_r <= lookup_en;
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                // Fence sweep clears both ways at one index
                if (fence_active) begin
                    valid_bits[w][fence_index] <= 1'b0;
                end else if (update && update_way[w]) begin
                    valid_bits[w][update_index] <= 1'b1;
                end
            end
        end
    end

    // Compare in second cycle
    always_comb begin
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            hit_way[w] = lookup_r & valid_r[w] & (tag_r[w] == cmp_tag);
        end
    end

    assign tag_hit = |hit_way;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam real HALF_PERIOD  = 4.0;
    localparam int  RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: tb_icache_subsys.sv
`timescale 1ns/1ps

module tb_icache_subsys;

    localparam int N_ON        = 120;
    localparam int N_OFF       = 24;
    localparam int N_REPLAY    = 16;
    localparam int N_BURST     = 8;
    localparam int N_FENCES    = 2;
    localparam int TOTAL_REQS  = N_ON + N_OFF + N_REPLAY + N_BURST;
    // Extra cycles for reset and register traffic
    localparam int CYCLE_LIMIT = 40 * TOTAL_REQS + N_FENCES * icache_pkg::LINES + 100;

    logic                                clk;
    logic                                rst;
    logic                                fetch_req;
    logic [icache_pkg::ADDR_W-1:0]       fetch_addr;
    logic                                fetch_ready;
    logic                                fetch_valid;
    logic [31:0]                         fetch_data;
    logic                                mem_request;
    logic [29:0]                         mem_addr;
    logic [4:0]                          mem_rlen;
    logic                                mem_ack;
    logic                                mem_rvalid;
    logic [31:0]                         mem_rdata;
    logic                                cfg_wr;
    icache_pkg::cfg_reg_e                cfg_addr;
    logic [31:0]                         cfg_wdata;
    logic [31:0]                         cfg_rdata;

    // Reference model state
    logic [31:0]                         lfsr_state;
    logic [31:0]                         resp_q [$];
    logic [29:0]                         line_q [$];
    logic [icache_pkg::TAG_W-1:0]        shadow_tag [icache_pkg::WAYS][icache_pkg::LINES];
    logic                                shadow_valid [icache_pkg::WAYS][icache_pkg::LINES];
    int                                  victim;
    logic                                model_on;
    int                                  exp_hits;
    int                                  exp_misses;
    logic [31:0]                         recent [N_REPLAY];
    logic                                burst_phase;
    logic                                stall_seen;
    logic                                mem_busy;
    int                                  cycle_count = 0;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    icache_subsys icache_subsys_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .mem_request (mem_request),
        .mem_addr    (mem_addr),
        .mem_rlen    (mem_rlen),
        .mem_ack     (mem_ack),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata)
    );

    ////////////////////
    // Random source and memory contents

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // XOR pattern rotated left by 5
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        logic [31:0] x;
        x = byte_addr ^ 32'hA5A5_0000;
        return {x[26:0], x[31:27]};
    endfunction

    // Four tags over four sets so ways get evicted
    function automatic logic [31:0] random_addr();
        logic [1:0]                         tag_sel;
        logic [1:0]                         set_sel;
        logic [2:0]                         word;
        logic [icache_pkg::TAG_W-1:0]       tag;
        tag_sel = 2'(rand_bits(2));
        set_sel = 2'(rand_bits(2));
        word    = 3'(rand_bits(3));
        case (tag_sel)
            2'd0:    tag = 21'h00000;
            2'd1:    tag = 21'h00001;
            2'd2:    tag = 21'h00155;
            default: tag = 21'h1ABCD;
        endcase
        return {tag, set_sel, 4'b0101, word, 2'b00};
    endfunction

    ////////////////////
    // Failure reporting and compares

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("ERR %0t ns: %s", $time, msg));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input logic [31:0] addr);
        if (got !== exp) begin
            report_mismatch($sformatf("fetch 0x%08h returned 0x%08h, expected 0x%08h",
                                      addr, got, exp));
        end
    endtask

    task automatic check_reg(input icache_pkg::cfg_reg_e addr, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("%s read 0x%08h, expected 0x%08h",
                                      addr.name(), got, exp));
        end
    endtask

    task automatic check_mem_addr(input logic [29:0] got, input logic [29:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("mem_addr 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    task automatic check_burst_len(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            report_mismatch($sformatf("mem_rlen %0d, expected %0d", got, exp));
        end
    endtask

    ////////////////////
    // Reference model

    // Requests are served strictly in order so the model predicts at acceptance
    task automatic model_accept(input logic [31:0] addr);
        logic [icache_pkg::LINE_ADDR_W-1:0] set;
        logic [icache_pkg::TAG_W-1:0]       tag;
        logic                               hit;
        set = addr[10:5];
        tag = addr[31:11];
        hit = 1'b0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (model_on && shadow_valid[w][set] && shadow_tag[w][set] == tag) begin
                hit = 1'b1;
            end
        end
        resp_q.push_back(addr);
        if (hit) begin
            exp_hits++;
        end else begin
            if (model_on) begin
                exp_misses++;
            end
            // Every fill takes the round-robin victim even while disabled
            line_q.push_back({addr[31:5], 3'b000});
            shadow_tag[victim][set]   = tag;
            shadow_valid[victim][set] = 1'b1;
            victim = (victim + 1) % icache_pkg::WAYS;
        end
    endtask

    always @(negedge clk) begin : fetch_monitor
        logic [31:0] done_addr;
        if (!rst) begin
            if (fetch_req && fetch_ready) begin
                model_accept(fetch_addr);
            end
            if (burst_phase && fetch_req && !fetch_ready) begin
                stall_seen = 1'b1;
            end
            if (fetch_valid) begin
                if (resp_q.size() == 0) begin
                    abort_run("fetch_valid pulsed with no request outstanding");
                end else begin
                    done_addr = resp_q.pop_front();
                    check_word(fetch_data, mem_word(done_addr), done_addr);
                end
            end
        end
    end

    ////////////////////
    // Memory responder
    initial begin : mem_responder
        logic [1:0]  ack_delay;
        logic [7:0]  gaps;
        logic [29:0] line;
        mem_ack    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_busy   = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_request) begin
                mem_busy = 1'b1;
                line     = mem_addr;
                if (line_q.size() == 0) begin
                    abort_run($sformatf("memory burst for 0x%08h that no miss explains", line));
                end else begin
                    check_mem_addr(line, line_q.pop_front());
                end
                // Eight-word burst
                check_burst_len(mem_rlen, 5'd7);
                ack_delay = 2'(rand_bits(2));
                gaps      = 8'(rand_bits(8));
                next_cycle();
                repeat (ack_delay) next_cycle();
                mem_ack = 1'b1;
                next_cycle();
                mem_ack = 1'b0;
                for (int i = 0; i < icache_pkg::LINE_WORDS; i++) begin
                    mem_rvalid = 1'b0;
                    if (gaps[i]) begin
                        next_cycle();
                    end
                    mem_rvalid = 1'b1;
                    mem_rdata  = mem_word({line + 30'(i), 2'b00});
                    next_cycle();
                end
                mem_rvalid = 1'b0;
                mem_busy   = 1'b0;
            end
        end
    end

    ////////////////////
    // Driver tasks

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_fetch(input logic [31:0] addr, input int gap);
        fetch_req  = 1'b1;
        fetch_addr = addr;
        @(negedge clk);
        while (!fetch_ready) begin
            @(negedge clk);
        end
        next_cycle();
        fetch_req = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic write_reg(input icache_pkg::cfg_reg_e addr, input logic [31:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic expect_reg(input icache_pkg::cfg_reg_e addr, input logic [31:0] exp);
        cfg_addr = addr;
        @(negedge clk);
        check_reg(addr, cfg_rdata, exp);
        next_cycle();
    endtask

    task automatic check_counters();
        expect_reg(icache_pkg::REG_HITS, exp_hits);
        expect_reg(icache_pkg::REG_MISSES, exp_misses);
    endtask

    // Done when every response and every burst has finished
    task automatic wait_idle();
        while (resp_q.size() != 0 || line_q.size() != 0 || mem_busy) begin
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    task automatic run_fence();
        int low_cycles;
        wait_idle();
        write_reg(icache_pkg::REG_FENCE, 32'd1);
        cfg_addr = icache_pkg::REG_STATUS;
        @(negedge clk);
        check_reg(icache_pkg::REG_STATUS, cfg_rdata, 32'd1);
        low_cycles = 0;
        while (!fetch_ready && low_cycles <= icache_pkg::LINES) begin
            low_cycles++;
            @(negedge clk);
        end
        if (low_cycles != icache_pkg::LINES) begin
            report_mismatch($sformatf("fetch_ready low %0d cycles in fence, expected %0d",
                                      low_cycles, icache_pkg::LINES));
        end
        check_reg(icache_pkg::REG_STATUS, cfg_rdata, 32'd0);
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            for (int s = 0; s < icache_pkg::LINES; s++) begin
                shadow_valid[w][s] = 1'b0;
            end
        end
        next_cycle();
    endtask

    ////////////////////
    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    ////////////////////
    // Test sequence
    initial begin
        logic [31:0] addr;
        int          gap;
        fetch_req   = 1'b0;
        fetch_addr  = '0;
        cfg_wr      = 1'b0;
        cfg_addr    = icache_pkg::REG_CTRL;
        cfg_wdata   = '0;
        lfsr_state  = 32'h4930_4800;
        victim      = 0;
        model_on    = 1'b0;
        exp_hits    = 0;
        exp_misses  = 0;
        burst_phase = 1'b0;
        stall_seen  = 1'b0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            for (int s = 0; s < icache_pkg::LINES; s++) begin
                shadow_valid[w][s] = 1'b0;
                shadow_tag[w][s]   = '0;
            end
        end

        @(negedge rst);
        next_cycle();
        if (fetch_valid !== 1'b0 || mem_request !== 1'b0) begin
            report_mismatch("fetch_valid or mem_request high after reset");
        end
        expect_reg(icache_pkg::REG_HITS, 32'd0);
        expect_reg(icache_pkg::REG_MISSES, 32'd0);
        expect_reg(icache_pkg::REG_STATUS, 32'd0);

        // Enabled cache with random traffic
        write_reg(icache_pkg::REG_CTRL, 32'd1);
        model_on = 1'b1;
        for (int i = 0; i < N_ON; i++) begin
            addr = random_addr();
            gap  = int'(rand_bits(2));
            if (i >= N_ON - N_REPLAY) begin
                recent[i - (N_ON - N_REPLAY)] = addr;
            end
            issue_fetch(addr, gap);
        end
        wait_idle();
        check_counters();

        // Disabled cache sends every request to memory
        write_reg(icache_pkg::REG_CTRL, 32'd0);
        model_on = 1'b0;
        for (int i = 0; i < N_OFF; i++) begin
            addr = random_addr();
            gap  = int'(rand_bits(2));
            issue_fetch(addr, gap);
        end
        wait_idle();
        check_counters();

        // Lines resident before a fence miss again after it
        write_reg(icache_pkg::REG_CTRL, 32'd1);
        model_on = 1'b1;
        run_fence();
        for (int i = 0; i < N_REPLAY; i++) begin
            gap = int'(rand_bits(1));
            issue_fetch(recent[i], gap);
        end
        wait_idle();
        check_counters();

        // Back to back behind a fill fills the input FIFO
        run_fence();
        burst_phase = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            addr = random_addr();
            issue_fetch(addr, 0);
        end
        burst_phase = 1'b0;
        wait_idle();
        if (!stall_seen) begin
            abort_run("fetch_ready never dropped with requests queued behind a fill");
        end
        check_counters();

        // Counter clear by register write
        write_reg(icache_pkg::REG_HITS, 32'd0);
        write_reg(icache_pkg::REG_MISSES, 32'd0);
        exp_hits   = 0;
        exp_misses = 0;
        check_counters();

        $display("TEST PASSED");
        $finish;
    end

endmodule
